/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen      = 64;
    localparam int addr_w    = 64;
    localparam int reg_idx_w = 5;
    localparam int inst_w    = 32;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;

    // arithmetic funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;

    // load/store funct3
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_double = 3'b011;

    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    // same codes as the bus size field
    typedef enum logic [1:0] {
        size_word   = 2'd2,
        size_double = 2'd3
    } mem_size_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [19:0] upper;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        u_fmt_t u;
    } inst_word_t;

endpackage

`default_nettype wire

/* src/decode_if.sv */
`default_nettype none

interface decode_if;
    import rv_pkg::*;

    logic [reg_idx_w-1:0] rs1_idx;
    logic [reg_idx_w-1:0] rs2_idx;
    logic [reg_idx_w-1:0] rd_idx;
    logic                 rd_en;
    logic [xlen-1:0]      imm;
    alu_op_t              alu_op;
    logic                 alu_src_imm;
    logic                 alu_src_pc;
    logic                 is_lui;
    logic                 is_jal;
    logic                 is_branch;
    logic [2:0]           branch_cond;
    logic                 mem_read;
    logic                 mem_write;
    mem_size_t            mem_size;

    modport decoder (
        output rs1_idx, rs2_idx, rd_idx, rd_en, imm, alu_op, alu_src_imm, alu_src_pc,
               is_lui, is_jal, is_branch, branch_cond, mem_read, mem_write, mem_size
    );
    modport sequencer (input rd_en, imm, is_lui, is_jal, mem_read, mem_write);
    modport execute (input imm, alu_op, alu_src_imm, alu_src_pc, is_branch, branch_cond);
    modport memory (input mem_read, mem_write, mem_size);

endinterface

`default_nettype wire

/* src/decoder.sv */
`default_nettype none

module decoder (
    input  rv_pkg::inst_word_t inst,
    decode_if.decoder          dec
);
    import rv_pkg::*;

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic            rd_write;
    logic            sign;

    function automatic alu_op_t arith_op(input logic [2:0] funct3, input logic sub);
        case (funct3)
            f3_add_sub: arith_op = sub ? alu_sub : alu_add;
            f3_slt:     arith_op = alu_slt;
            f3_xor:     arith_op = alu_xor;
            f3_or:      arith_op = alu_or;
            f3_and:     arith_op = alu_and;
            default:    arith_op = alu_add;
        endcase
    endfunction

    assign sign = inst.r.funct7[6];

    assign imm_i = {{52{sign}}, inst.r.funct7, inst.r.rs2};
    assign imm_s = {{52{sign}}, inst.r.funct7, inst.r.rd};
    assign imm_b = {{52{sign}}, inst.r.rd[0], inst.r.funct7[5:0], inst.r.rd[4:1], 1'b0};
    // upper field seen as U and as the scrambled J offset
    assign imm_u = {{32{sign}}, inst.u.upper, 12'b0};
    assign imm_j = {{44{sign}}, inst.u.upper[7:0], inst.u.upper[8], inst.u.upper[18:9], 1'b0};

    assign dec.rs1_idx = inst.r.rs1;
    assign dec.rs2_idx = inst.r.rs2;
    assign dec.rd_idx  = inst.r.rd;
    assign dec.rd_en   = rd_write && (inst.r.rd != '0);

    always_comb begin
        rd_write        = 1'b0;
        dec.imm         = imm_i;
        dec.alu_op      = alu_add;
        dec.alu_src_imm = 1'b0;
        dec.alu_src_pc  = 1'b0;
        dec.is_lui      = 1'b0;
        dec.is_jal      = 1'b0;
        dec.is_branch   = 1'b0;
        dec.branch_cond = inst.r.funct3;
        dec.mem_read    = 1'b0;
        dec.mem_write   = 1'b0;
        dec.mem_size    = (inst.r.funct3 == f3_double) ? size_double : size_word;
        case (inst.r.opcode)
            op_lui: begin
                rd_write    = 1'b1;
                dec.imm     = imm_u;
                dec.alu_op  = alu_pass_b;
                dec.alu_src_imm = 1'b1;
                dec.is_lui  = 1'b1;
            end
            op_jal: begin
                rd_write        = 1'b1;
                dec.imm         = imm_j;
                dec.alu_src_imm = 1'b1;
                dec.alu_src_pc  = 1'b1;
                dec.is_jal      = 1'b1;
            end
            op_imm: begin
                rd_write        = 1'b1;
                dec.alu_op      = arith_op(inst.r.funct3, 1'b0);
                dec.alu_src_imm = 1'b1;
            end
            op_reg: begin
                rd_write   = 1'b1;
                dec.alu_op = arith_op(inst.r.funct3, inst.r.funct7 == f7_sub);
            end
            op_branch: begin
                dec.imm         = imm_b;
                dec.alu_src_imm = 1'b1;
                dec.alu_src_pc  = 1'b1;
                dec.is_branch   = 1'b1;
            end
            op_load: begin
                rd_write        = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.mem_read    = 1'b1;
            end
            op_store: begin
                dec.imm         = imm_s;
                dec.alu_src_imm = 1'b1;
                dec.mem_write   = 1'b1;
            end
            // anything else retires as a nop
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* src/regfile.sv */
`default_nettype none

module regfile (
    input  logic                         inst_selfdefine,
    input  logic                         reset,
    input  logic [rv_pkg::reg_idx_w-1:0] rs1_idx,
    input  logic [rv_pkg::reg_idx_w-1:0] rs2_idx,
    input  logic [rv_pkg::reg_idx_w-1:0] rd_idx,
    input  logic                         wr_en,
    input  logic [rv_pkg::xlen-1:0]      wr_data,
    output logic [rv_pkg::xlen-1:0]      rs1_data,
    output logic [rv_pkg::xlen-1:0]      rs2_data
);
    import rv_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (rd_idx != '0)) begin
            regs[rd_idx] <= wr_data;
        end
    end

    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1_idx != '0) begin
            rs1_data = regs[rs1_idx];
        end
        if (rs2_idx != '0) begin
            rs2_data = regs[rs2_idx];
        end
    end

endmodule

`default_nettype wire

/* src/alu.sv */
`default_nettype none

module alu (
    decode_if.execute               dec,
    input  logic [rv_pkg::addr_w-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    branch_taken
);
    import rv_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic            cond;

    assign op_a = dec.alu_src_pc ? pc : rs1_data;
    assign op_b = dec.alu_src_imm ? dec.imm : rs2_data;

    always_comb begin
        case (dec.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_and:    result = op_a & op_b;
            alu_or:     result = op_a | op_b;
            alu_xor:    result = op_a ^ op_b;
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_pass_b: result = op_b;
            default:    result = op_a + op_b;
        endcase
    end

    // branch compare always looks at the registers, the adder makes the target
    always_comb begin
        case (dec.branch_cond)
            f3_beq:  cond = (rs1_data == rs2_data);
            f3_bne:  cond = (rs1_data != rs2_data);
            f3_blt:  cond = ($signed(rs1_data) < $signed(rs2_data));
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = dec.is_branch && cond;

endmodule

`default_nettype wire

/* src/lsu.sv */
`default_nettype none

module lsu (
    input  logic                      inst_selfdefine,
    input  logic                      reset,
    decode_if.memory                  dec,
    input  logic                      start,
    input  logic [rv_pkg::addr_w-1:0] addr,
    input  logic [rv_pkg::xlen-1:0]   store_data,
    output logic                      done,
    output logic [rv_pkg::xlen-1:0]   load_data,

    output logic                      mem_valid,
    output logic [rv_pkg::addr_w-1:0] mem_addr,
    output logic [rv_pkg::xlen-1:0]   mem_data_write,
    output logic [1:0]                mem_size,
    output logic                      mem_req,
    input  logic                      mem_ready,
    input  logic [rv_pkg::xlen-1:0]   mem_data_read
);
    import rv_pkg::*;

    logic        access;
    logic [31:0] word_data;

    assign access = start && (dec.mem_read || dec.mem_write);

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            mem_valid <= 1'b0;
            mem_req   <= 1'b0;
        end else if (access) begin
            mem_valid <= 1'b1;
            mem_req   <= dec.mem_write;
        end else if (mem_ready) begin
            mem_valid <= 1'b0;
            mem_req   <= 1'b0;
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (access) begin
            mem_addr       <= addr;
            mem_data_write <= store_data;
            mem_size       <= dec.mem_size;
        end
    end

    assign done = mem_valid && mem_ready;

    // bus data is right aligned, word loads sign extend
    assign word_data = mem_data_read[31:0];
    assign load_data = (mem_size == size_word) ? {{32{word_data[31]}}, word_data}
                                               : mem_data_read;

endmodule

`default_nettype wire

/* src/core_sequencer.sv */
`default_nettype none

module core_sequencer #(
    parameter logic [rv_pkg::addr_w-1:0] pc_start = 64'h8000_0000
) (
    input  logic                      inst_selfdefine,
    input  logic                      reset,
    decode_if.sequencer               dec,

    output logic                      if_valid,
    output logic [rv_pkg::addr_w-1:0] if_addr,
    input  logic                      if_ready,
    input  logic [rv_pkg::inst_w-1:0] if_data_read,

    output rv_pkg::inst_word_t        inst,
    output logic [rv_pkg::addr_w-1:0] pc,
    input  logic [rv_pkg::xlen-1:0]   alu_result,
    input  logic                      branch_taken,
    input  logic [rv_pkg::xlen-1:0]   load_data,
    output logic                      lsu_start,
    input  logic                      lsu_done,
    output logic                      wr_en,
    output logic [rv_pkg::xlen-1:0]   wr_data
);
    import rv_pkg::*;

    localparam logic [1:0] st_fetch   = 2'd0;
    localparam logic [1:0] st_execute = 2'd1;
    localparam logic [1:0] st_memory  = 2'd2;

    logic [1:0]        state;
    logic [addr_w-1:0] pc_plus4;
    logic [addr_w-1:0] next_pc;
    logic              mem_op;
    logic              fetch_done;

    assign pc_plus4   = pc + 64'd4;
    assign next_pc    = (dec.is_jal || branch_taken) ? alu_result : pc_plus4;
    assign mem_op     = dec.mem_read || dec.mem_write;
    assign fetch_done = (state == st_fetch) && if_valid && if_ready;
    assign if_addr    = pc;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state    <= st_fetch;
            if_valid <= 1'b0;
            pc       <= pc_start;
        end else begin
            case (state)
                st_fetch: begin
                    if (!if_valid) begin
                        if_valid <= 1'b1;
                    end else if (if_ready) begin
                        if_valid <= 1'b0;
                        state    <= st_execute;
                    end
                end
                st_execute: begin
                    if (mem_op) begin
                        state <= st_memory;
                    end else begin
                        pc       <= next_pc;
                        if_valid <= 1'b1;
                        state    <= st_fetch;
                    end
                end
                st_memory: begin
                    if (lsu_done) begin
                        pc       <= next_pc;
                        if_valid <= 1'b1;
                        state    <= st_fetch;
                    end
                end
                default: state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (fetch_done) begin
            inst <= if_data_read;
        end
    end

    assign lsu_start = (state == st_execute) && mem_op;

    // one write-back cycle per instruction
    assign wr_en = dec.rd_en && (((state == st_execute) && !mem_op) ||
                                 ((state == st_memory) && lsu_done && dec.mem_read));

    always_comb begin
        if (dec.is_jal) begin
            wr_data = pc_plus4;
        end else if (dec.is_lui) begin
            wr_data = dec.imm;
        end else if (dec.mem_read) begin
            wr_data = load_data;
        end else begin
            wr_data = alu_result;
        end
    end

endmodule

`default_nettype wire

/* src/cpu.sv */
`default_nettype none

module cpu #(
    parameter logic [rv_pkg::addr_w-1:0] pc_start = 64'h8000_0000
) (
    input  logic                      inst_selfdefine,
    input  logic                      reset,

    output logic                      if_valid,
    output logic [rv_pkg::addr_w-1:0] if_addr,
    input  logic                      if_ready,
    input  logic [rv_pkg::inst_w-1:0] if_data_read,

    output logic                      mem_valid,
    output logic [rv_pkg::addr_w-1:0] mem_addr,
    output logic [rv_pkg::xlen-1:0]   mem_data_write,
    output logic [1:0]                mem_size,
    output logic                      mem_req,
    input  logic                      mem_ready,
    input  logic [rv_pkg::xlen-1:0]   mem_data_read
);
    import rv_pkg::*;

    inst_word_t        inst;
    logic [addr_w-1:0] pc;
    logic [xlen-1:0]   rs1_data;
    logic [xlen-1:0]   rs2_data;
    logic [xlen-1:0]   alu_result;
    logic              branch_taken;
    logic [xlen-1:0]   load_data;
    logic              lsu_start;
    logic              lsu_done;
    logic              wr_en;
    logic [xlen-1:0]   wr_data;

    decode_if dec ();

    decoder i_decoder (.inst(inst), .dec(dec));

    regfile i_regfile (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .rs1_idx         (dec.rs1_idx),
        .rs2_idx         (dec.rs2_idx),
        .rd_idx          (dec.rd_idx),
        .wr_en           (wr_en),
        .wr_data         (wr_data),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data)
    );

    alu i_alu (
        .dec          (dec),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    lsu i_lsu (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .dec             (dec),
        .start           (lsu_start),
        .addr            (alu_result),
        .store_data      (rs2_data),
        .done            (lsu_done),
        .load_data       (load_data),
        .mem_valid       (mem_valid),
        .mem_addr        (mem_addr),
        .mem_data_write  (mem_data_write),
        .mem_size        (mem_size),
        .mem_req         (mem_req),
        .mem_ready       (mem_ready),
        .mem_data_read   (mem_data_read)
    );

    core_sequencer #(.pc_start(pc_start)) i_core_sequencer (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .dec             (dec),
        .if_valid        (if_valid),
        .if_addr         (if_addr),
        .if_ready        (if_ready),
        .if_data_read    (if_data_read),
        .inst            (inst),
        .pc              (pc),
        .alu_result      (alu_result),
        .branch_taken    (branch_taken),
        .load_data       (load_data),
        .lsu_start       (lsu_start),
        .lsu_done        (lsu_done),
        .wr_en           (wr_en),
        .wr_data         (wr_data)
    );

endmodule

`default_nettype wire

/* verification/cpu_props.sv */
`default_nettype none

module cpu_props (
    input wire logic        inst_selfdefine,
    input wire logic        reset,
    input wire logic        if_valid,
    input wire logic [63:0] if_addr,
    input wire logic        if_ready,
    input wire logic        mem_valid,
    input wire logic [63:0] mem_addr,
    input wire logic        mem_ready
);

    assert property (@(posedge inst_selfdefine) disable iff (reset)
        if_valid && !if_ready |=> if_valid && $stable(if_addr))
        else $error("fetch request dropped or changed before ready");

    assert property (@(posedge inst_selfdefine) disable iff (reset)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr))
        else $error("data request dropped or changed before ready");

    assert property (@(posedge inst_selfdefine) !(if_valid && mem_valid))
        else $error("both bus requests active");

    // outputs settle one edge into reset
    assert property (@(posedge inst_selfdefine) reset && $past(reset) |-> !if_valid && !mem_valid)
        else $error("bus request active during reset");

endmodule

bind cpu cpu_props i_cpu_props (
    .inst_selfdefine (inst_selfdefine),
    .reset           (reset),
    .if_valid        (if_valid),
    .if_addr         (if_addr),
    .if_ready        (if_ready),
    .mem_valid       (mem_valid),
    .mem_addr        (mem_addr),
    .mem_ready       (mem_ready)
);

`default_nettype wire

/* verification/cpu_tb.sv */
`default_nettype none

module cpu_tb;

    localparam logic [63:0] pc_base   = 64'h8000_0000;
    localparam int          imem_words = 64;
    localparam logic [31:0] nop_word   = 32'h0000_0013;

    logic        inst_selfdefine;
    logic        reset;
    logic        if_valid;
    logic [63:0] if_addr;
    logic        if_ready;
    logic [31:0] if_data_read;
    logic        mem_valid;
    logic [63:0] mem_addr;
    logic [63:0] mem_data_write;
    logic [1:0]  mem_size;
    logic        mem_req;
    logic        mem_ready;
    logic [63:0] mem_data_read;

    logic [31:0] imem [imem_words];
    logic [63:0] dmem [logic [63:0]];
    logic [63:0] fetch_log [$];
    logic [63:0] store_addr [$];
    logic [63:0] store_data [$];
    logic [1:0]  store_size [$];
    logic [63:0] end_pc;
    logic        end_seen;

    integer      seed = 32'h99f2f814;
    logic [31:0] draw;
    logic        if_pending;
    logic        mem_pending;
    int          if_wait;
    int          mem_wait;

    cpu #(.pc_start(pc_base)) i_cpu (.*);

    initial begin
        inst_selfdefine = 1'b0;
        forever #50 inst_selfdefine = ~inst_selfdefine;
    end

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // unwritten data words follow the address
    function automatic logic [63:0] read_dmem(input logic [63:0] addr);
        if (dmem.exists(addr)) begin
            return dmem[addr];
        end
        return addr ^ 64'hc3a5_96e1_0f2d_4b78;
    endfunction

    // bus models driven on the falling edge
    always @(negedge inst_selfdefine) begin
        logic [63:0] offset;
        if (reset) begin
            if_ready    = 1'b0;
            mem_ready   = 1'b0;
            if_pending  = 1'b0;
            mem_pending = 1'b0;
        end else begin
            if (if_ready) begin
                if_ready   = 1'b0;
                if_pending = 1'b0;
            end else if (if_valid) begin
                if (!if_pending) begin
                    if_pending = 1'b1;
                    draw       = $random(seed);
                    if_wait    = int'(draw[1:0]);
                end
                if (if_wait == 0) begin
                    offset       = (if_addr - pc_base) >> 2;
                    if_ready     = 1'b1;
                    if_data_read = (offset < imem_words) ? imem[offset[5:0]] : nop_word;
                    fetch_log.push_back(if_addr);
                    if (if_addr == end_pc) begin
                        end_seen = 1'b1;
                    end
                end else begin
                    if_wait--;
                end
            end
            if (mem_ready) begin
                mem_ready   = 1'b0;
                mem_pending = 1'b0;
            end else if (mem_valid) begin
                if (!mem_pending) begin
                    mem_pending = 1'b1;
                    draw        = $random(seed);
                    mem_wait    = int'(draw[1:0]);
                end
                if (mem_wait == 0) begin
                    mem_ready = 1'b1;
                    if (mem_req) begin
                        store_addr.push_back(mem_addr);
                        store_data.push_back(mem_data_write);
                        store_size.push_back(mem_size);
                        dmem[mem_addr] = mem_data_write;
                    end else begin
                        mem_data_read = read_dmem(mem_addr);
                    end
                end else begin
                    mem_wait--;
                end
            end
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1, "check of %s failed", name);
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = nop_word;
        end
        dmem.delete();
    endtask

    // the last instruction of every program is a jal to itself
    task automatic run_program(input int end_off);
        int cycles;
        imem[end_off / 4] = encode_j(21'd0, 5'd0);
        end_pc   = pc_base + 64'(end_off);
        end_seen = 1'b0;
        @(negedge inst_selfdefine);
        reset = 1'b1;
        fetch_log.delete();
        store_addr.delete();
        store_data.delete();
        store_size.delete();
        repeat (10) @(negedge inst_selfdefine);
        reset  = 1'b0;
        cycles = 0;
        while (!end_seen) begin
            @(negedge inst_selfdefine);
            cycles++;
            if (cycles > 1000) begin
                $display("Errors found");
                $fatal(1, "program never reached its final instruction");
            end
        end
    endtask

    task automatic check_store(input int idx, input logic [63:0] addr, input logic [63:0] data,
                               input logic [1:0] size);
        if (idx >= store_data.size()) begin
            $display("Errors found");
            $fatal(1, "expected store number %0d never reached the data bus", idx);
        end
        check("mem_addr", store_addr[idx], addr);
        check("mem_data_write", store_data[idx], data);
        check("mem_size", 64'(store_size[idx]), 64'(size));
    endtask

    task automatic check_next_fetch(input int from_off, input int to_off);
        int idx;
        idx = -1;
        for (int i = 0; i + 1 < fetch_log.size(); i++) begin
            if (idx < 0 && fetch_log[i] == pc_base + 64'(from_off)) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("Errors found");
            $fatal(1, "instruction at offset %0d was never fetched", from_off);
        end
        check("if_addr", fetch_log[idx + 1], pc_base + 64'(to_off));
    endtask

    task automatic test_fetch();
        clear_program();
        for (int i = 0; i < 4; i++) begin
            imem[i] = encode_i(12'(i + 1), 5'd0, 3'b000, 5'(i + 1), 7'h13);
        end
        run_program(16);
        for (int i = 0; i < 5; i++) begin
            check("if_addr", fetch_log[i], pc_base + 64'(4 * i));
        end
    endtask

    task automatic test_arith();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] exp [7];
        a = 64'd100;
        b = -64'sd7;
        exp[0] = a + b;
        exp[1] = a - b;
        exp[2] = a & b;
        exp[3] = a | b;
        exp[4] = a ^ b;
        exp[5] = ($signed(b) < $signed(a)) ? 64'd1 : 64'd0;
        exp[6] = {{32{1'b1}}, 32'habcd_e000};
        clear_program();
        imem[0] = encode_i(12'd100, 5'd0, 3'b000, 5'd1, 7'h13);
        imem[1] = encode_i(12'hff9, 5'd0, 3'b000, 5'd2, 7'h13);
        imem[2] = encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
        imem[3] = encode_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);
        imem[4] = encode_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5);
        imem[5] = encode_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);
        imem[6] = encode_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7);
        imem[7] = encode_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd8);
        imem[8] = {20'habcde, 5'd9, 7'h37};
        for (int k = 0; k < 7; k++) begin
            imem[9 + k] = encode_s(12'(12'h100 + 8 * k), 5'(3 + k), 5'd0, 3'b011);
        end
        run_program(64);
        for (int k = 0; k < 7; k++) begin
            check_store(k, 64'h100 + 64'(8 * k), exp[k], 2'd3);
        end
    endtask

    task automatic test_branch();
        clear_program();
        imem[0]  = encode_i(12'd5, 5'd0, 3'b000, 5'd1, 7'h13);
        imem[1]  = encode_i(12'd5, 5'd0, 3'b000, 5'd2, 7'h13);
        imem[2]  = encode_i(12'hfff, 5'd0, 3'b000, 5'd3, 7'h13);
        imem[3]  = encode_b(13'd8, 5'd2, 5'd1, 3'b000);
        imem[5]  = encode_b(13'd8, 5'd2, 5'd1, 3'b001);
        imem[6]  = encode_b(13'd12, 5'd1, 5'd3, 3'b100);
        imem[9]  = encode_b(13'd8, 5'd3, 5'd1, 3'b100);
        imem[10] = encode_b(13'd8, 5'd3, 5'd1, 3'b001);
        imem[12] = encode_b(13'd8, 5'd3, 5'd1, 3'b000);
        run_program(52);
        // taken at 12, 24 and 40
        // not taken at 20, 36 and 48
        check_next_fetch(12, 20);
        check_next_fetch(20, 24);
        check_next_fetch(24, 36);
        check_next_fetch(36, 40);
        check_next_fetch(40, 48);
        check_next_fetch(48, 52);
    endtask

    task automatic test_jal();
        clear_program();
        imem[0] = encode_j(21'd12, 5'd1);
        imem[3] = encode_s(12'h200, 5'd1, 5'd0, 3'b011);
        run_program(16);
        check_next_fetch(0, 12);
        check_store(0, 64'h200, pc_base + 64'd4, 2'd3);
    endtask

    task automatic test_load();
        clear_program();
        dmem[64'h300] = 64'h0000_0000_8765_4321;
        dmem[64'h308] = 64'h1234_5678_9abc_def0;
        imem[0] = encode_i(12'h300, 5'd0, 3'b010, 5'd1, 7'h03);
        imem[1] = encode_i(12'h308, 5'd0, 3'b011, 5'd2, 7'h03);
        imem[2] = encode_s(12'h310, 5'd1, 5'd0, 3'b011);
        imem[3] = encode_s(12'h318, 5'd2, 5'd0, 3'b011);
        imem[4] = encode_s(12'h320, 5'd2, 5'd0, 3'b010);
        run_program(20);
        check_store(0, 64'h310, 64'hffff_ffff_8765_4321, 2'd3);
        check_store(1, 64'h318, 64'h1234_5678_9abc_def0, 2'd3);
        check("mem_size", 64'(store_size[2]), 64'd2);
        check("mem_addr", store_addr[2], 64'h320);
    endtask

    task automatic test_x0();
        clear_program();
        imem[0] = encode_i(12'd55, 5'd0, 3'b000, 5'd0, 7'h13);
        imem[1] = encode_s(12'h400, 5'd0, 5'd0, 3'b011);
        run_program(8);
        check_store(0, 64'h400, 64'd0, 2'd3);
    endtask

    initial begin
        reset         = 1'b1;
        if_ready      = 1'b0;
        if_data_read  = nop_word;
        mem_ready     = 1'b0;
        mem_data_read = '0;
        end_pc        = '0;
        end_seen      = 1'b0;
        test_fetch();
        test_arith();
        test_branch();
        test_jal();
        test_load();
        test_x0();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* cpu.f */
src/rv_pkg.sv
src/decode_if.sv
src/decoder.sv
src/regfile.sv
src/alu.sv
src/lsu.sv
src/core_sequencer.sv
src/cpu.sv
verification/cpu_props.sv
verification/cpu_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f cpu.f --top-module cpu_tb -o cpu_sim && \
    ./obj_dir/cpu_sim || exit 1
